//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = lenet_tb
FILELIST = compile.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- compile.f
+incdir+.
lenet_pkg.sv
line_buffer_mem.sv
conv_engine.sv
pool_engine.sv
layer_sequencer.sv
lenet_top.sv
lenet_sva.sv
lenet_tb.sv

//--- conv_engine.sv
`default_nettype none

`include "lenet_settings.svh"

module conv_engine
(
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     conv_start,
    input  wire lenet_pkg::kernel_t kernel,
    output lenet_pkg::mem_rd_t      img_rd,
    input  wire [`DATA_W-1:0]       img_data,
    output lenet_pkg::mem_wr_t      map_wr,
    output logic                    conv_done
);

    localparam int pos_w   = $clog2(`MAP_DIM);
    localparam int ki_w    = $clog2(`K_DIM);
    localparam int tap_w   = $clog2(`K_DIM * `K_DIM);
    localparam int sat_max = 2 ** (`DATA_W - 1) - 1;
    localparam int sat_min = -(2 ** (`DATA_W - 1));

    lenet_pkg::kernel_t kernel_q;

    logic               running;
    logic [pos_w-1:0]   row;
    logic [pos_w-1:0]   col;
    logic [ki_w-1:0]    kr;
    logic [ki_w-1:0]    kc;
    logic               rd_vld;
    logic [tap_w-1:0]   tap_q;
    logic [`ADDR_W-1:0] out_addr_q;
    logic               wr_en;
    logic [`ADDR_W-1:0] wr_addr;
    logic [`DATA_W-1:0] wr_data;

    logic signed [`ACC_W-1:0]  acc;
    logic signed [`ACC_W-1:0]  prod;
    logic signed [`ACC_W-1:0]  bias_term;
    logic signed [`ACC_W-1:0]  sum_next;
    logic signed [`ACC_W-1:0]  shifted;
    logic signed [`DATA_W-1:0] sat_val;

    ////////////////////////////////////////////////////////////
    // read issue, kc innermost then kr, col, row
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            running <= 1'b0;
            row     <= '0;
            col     <= '0;
            kr      <= '0;
            kc      <= '0;
        end
        else if (!running)
        begin
            running <= conv_start;
        end
        else
        begin
            kc <= kc + 1'b1;
            if (kc == ki_w'(`K_DIM - 1))
            begin
                kc <= '0;
                kr <= kr + 1'b1;
                if (kr == ki_w'(`K_DIM - 1))
                begin
                    kr  <= '0;
                    col <= col + 1'b1;
                    if (col == pos_w'(`MAP_DIM - 1))
                    begin
                        col <= '0;
                        row <= row + 1'b1;
                        if (row == pos_w'(`MAP_DIM - 1))
                        begin
                            row     <= '0;
                            running <= 1'b0;
                        end
                    end
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // multiply-accumulate on the returned pixel
    always_comb
    begin
        img_rd.en   = running;
        img_rd.addr = `ADDR_W'((row + kr) * `IMG_DIM + col + kc);
        // pixel is unsigned, weight signed
        prod      = $signed({1'b0, img_data}) * $signed(kernel_q.weight[tap_q]);
        bias_term = kernel_q.bias <<< `FRAC_SHIFT;
        sum_next  = ((tap_q == '0) ? bias_term : acc) + prod;
        shifted   = sum_next >>> `FRAC_SHIFT;
        if (shifted > sat_max)
            sat_val = `DATA_W'(sat_max);
        else if (shifted < sat_min)
            sat_val = `DATA_W'(sat_min);
        else
            sat_val = shifted[`DATA_W-1:0];
        map_wr.en   = wr_en;
        map_wr.addr = wr_addr;
        map_wr.data = wr_data;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rd_vld    <= 1'b0;
            wr_en     <= 1'b0;
            conv_done <= 1'b0;
        end
        else
        begin
            rd_vld    <= running;
            wr_en     <= rd_vld && (tap_q == tap_w'(`K_DIM * `K_DIM - 1));
            // last map word lands at the edge before this
            conv_done <= wr_en && (wr_addr == `ADDR_W'(`MAP_DIM * `MAP_DIM - 1));
        end
    end

    always_ff @(posedge clk)
    begin
        if (conv_start && !running)
            kernel_q <= kernel;
        tap_q      <= tap_w'(kr * `K_DIM + kc);
        out_addr_q <= `ADDR_W'(row * `MAP_DIM + col);
        if (rd_vld)
            acc <= sum_next;
        wr_addr <= out_addr_q;
        wr_data <= sat_val;
    end

endmodule

`default_nettype wire

//--- layer_sequencer.sv
`default_nettype none

module layer_sequencer
(
    input  wire  clk,
    input  wire  rst,
    input  wire  start,
    input  wire  conv_done,
    input  wire  pool_done,
    output logic conv_start,
    output logic pool_start,
    output logic busy,
    output logic finish
);

    typedef enum logic [1:0] {
        idle_st,
        conv_st,
        pool_st
    } state_t;

    state_t state;

    ////////////////////////////////////////////////////////////
    // one engine at a time, start pulses are single cycle
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state      <= idle_st;
            conv_start <= 1'b0;
            pool_start <= 1'b0;
            finish     <= 1'b0;
        end
        else
        begin
            conv_start <= 1'b0;
            pool_start <= 1'b0;
            finish     <= 1'b0;
            case (state)
                idle_st:
                begin
                    if (start)
                    begin
                        state      <= conv_st;
                        conv_start <= 1'b1;
                    end
                end
                conv_st:
                begin
                    if (conv_done)
                    begin
                        state      <= pool_st;
                        pool_start <= 1'b1;
                    end
                end
                pool_st:
                begin
                    // result is already written when pool_done arrives
                    if (pool_done)
                    begin
                        state  <= idle_st;
                        finish <= 1'b1;
                    end
                end
                default:
                begin
                    state <= idle_st;
                end
            endcase
        end
    end

    // falls in the same cycle finish rises
    assign busy = (state != idle_st);

endmodule

`default_nettype wire

//--- lenet_pkg.sv
`default_nettype none

`include "lenet_settings.svh"

package lenet_pkg;

    // one word written per cycle
    typedef struct packed {
        logic               en;
        logic [`ADDR_W-1:0] addr;
        logic [`DATA_W-1:0] data;
    } mem_wr_t;

    // data comes back the cycle after en
    typedef struct packed {
        logic               en;
        logic [`ADDR_W-1:0] addr;
    } mem_rd_t;

    // weight[0] is the top-left tap, row-major
    typedef struct packed {
        logic [0:`K_DIM*`K_DIM-1][`DATA_W-1:0] weight;
        logic signed [`DATA_W-1:0]             bias;
    } kernel_t;

    // value[0] is the top-left block, row-major
    typedef struct packed {
        logic [0:`POOL_DIM*`POOL_DIM-1][`DATA_W-1:0] value;
    } pool_result_t;

endpackage

`default_nettype wire

//--- lenet_settings.svh
`ifndef LENET_SETTINGS_SVH
`define LENET_SETTINGS_SVH

// image side, pixels per row
`define IMG_DIM 8

// kernel side
`define K_DIM 3

// valid convolution output side
`define MAP_DIM 6

// 2x2 pooling of the map
`define POOL_DIM 3

// pixel and activation width
`define DATA_W 8

// accumulator, holds nine full products plus bias
`define ACC_W 20

// 64 words per memory at most
`define ADDR_W 6

// fixed-point scaling after accumulation
`define FRAC_SHIFT 4

`endif

//--- lenet_sva.sv
`default_nettype none

module lenet_sva
(
    input wire                          clk,
    input wire                          rst,
    input wire                          busy,
    input wire                          finish,
    input wire lenet_pkg::pool_result_t result
);

    ////////////////////////////////////////////////////////////
    // control timing at the top level
    finish_pulse: assert property (@(posedge clk) disable iff (rst) finish |=> !finish)
        else $error("finish held for more than one cycle");

    finish_idle: assert property (@(posedge clk) disable iff (rst) finish |-> !busy)
        else $error("finish raised while busy");

    // pool writes only happen during a run
    result_hold: assert property (@(posedge clk) disable iff (rst) !busy |-> $stable(result))
        else $error("result changed while idle");

endmodule

bind lenet_top lenet_sva sva_i (
    .clk    (clk),
    .rst    (rst),
    .busy   (busy),
    .finish (finish),
    .result (result)
);

`default_nettype wire

//--- lenet_tb.sv
`default_nettype none

`include "lenet_settings.svh"

module lenet_tb;

    localparam int half_period = 20;
    localparam int num_tests   = 5;
    localparam int run_limit   = 1000;
    localparam int n_pix       = `IMG_DIM * `IMG_DIM;
    localparam int n_taps      = `K_DIM * `K_DIM;
    localparam int n_out       = `POOL_DIM * `POOL_DIM;

    logic                    clk;
    logic                    rst;
    logic                    start;
    lenet_pkg::mem_wr_t      img_wr;
    lenet_pkg::kernel_t      kernel;
    logic                    busy;
    logic                    finish;
    lenet_pkg::pool_result_t result;

    logic [`DATA_W-1:0] image [n_pix];
    logic [31:0]        lfsr_state;
    int                 val_errors   = 0;
    int                 misc_errors  = 0;
    int                 finish_count = 0;

    lenet_top dut_i (
        .clk    (clk),
        .rst    (rst),
        .img_wr (img_wr),
        .kernel (kernel),
        .start  (start),
        .busy   (busy),
        .finish (finish),
        .result (result)
    );

    always #(half_period) clk = ~clk;

    always @(negedge clk)
    begin
        if (finish)
            finish_count <= finish_count + 1;
    end

    // run_limit cycles for each test
    initial
    begin
        #(num_tests * run_limit * 2 * half_period);
        $display("watchdog expired before the tests completed");
        $display("TESTS FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // stimulus helpers
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
            bits = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    // small signed weights keep most map values off the rails
    function automatic lenet_pkg::kernel_t random_kernel();
        lenet_pkg::kernel_t k;
        logic [3:0]         w;
        for (int t = 0; t < n_taps; t++)
        begin
            w = 4'(lfsr_bits(4));
            k.weight[t] = {{4{w[3]}}, w};
        end
        k.bias = 8'(lfsr_bits(8));
        return k;
    endfunction

    task automatic random_image();
        for (int i = 0; i < n_pix; i++)
            image[i] = 8'(lfsr_bits(8));
    endtask

    ////////////////////////////////////////////////////////////
    // reference model of conv then 2x2 max with relu
    function automatic lenet_pkg::pool_result_t model_result(input lenet_pkg::kernel_t k);
        int                      fmap [`MAP_DIM * `MAP_DIM];
        int                      acc;
        int                      best;
        int                      v;
        lenet_pkg::pool_result_t res;
        for (int r = 0; r < `MAP_DIM; r++)
        begin
            for (int c = 0; c < `MAP_DIM; c++)
            begin
                acc = int'($signed(k.bias)) * (2 ** `FRAC_SHIFT);
                for (int t = 0; t < n_taps; t++)
                begin
                    acc += int'(image[(r + t / `K_DIM) * `IMG_DIM + c + t % `K_DIM])
                        * int'($signed(k.weight[t]));
                end
                acc = acc >>> `FRAC_SHIFT;
                fmap[r * `MAP_DIM + c] = (acc > 127) ? 127 : ((acc < -128) ? -128 : acc);
            end
        end
        for (int b = 0; b < n_out; b++)
        begin
            best = -128;
            for (int q = 0; q < 4; q++)
            begin
                v = fmap[(2 * (b / `POOL_DIM) + q / 2) * `MAP_DIM + 2 * (b % `POOL_DIM) + q % 2];
                if (v > best)
                    best = v;
            end
            res.value[b] = (best < 0) ? 8'd0 : 8'(best);
        end
        return res;
    endfunction

    ////////////////////////////////////////////////////////////
    // DUT access and checks
    task automatic load_image();
        for (int i = 0; i < n_pix; i++)
        begin
            @(posedge clk);
            img_wr.en   <= 1'b1;
            img_wr.addr <= `ADDR_W'(i);
            img_wr.data <= image[i];
        end
        @(posedge clk);
        img_wr.en <= 1'b0;
    endtask

    // kernel stays on the port until the next run
    task automatic start_run(input lenet_pkg::kernel_t k);
        @(posedge clk);
        kernel <= k;
        start  <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("error %s: expected %h, got %h", name, exp, got);
            val_errors++;
        end
    endtask

    task automatic check_result(input lenet_pkg::pool_result_t exp);
        for (int i = 0; i < n_out; i++)
        begin
            if (result.value[i] !== exp.value[i])
            begin
                $display("error result.value[%0d]: expected %h, got %h",
                         i, exp.value[i], result.value[i]);
                val_errors++;
            end
        end
    endtask

    task automatic check_zero();
        if (result !== '0)
        begin
            $display("error result: expected %h, got %h", 72'h0, result);
            val_errors++;
        end
    endtask

    task automatic finish_and_check(input lenet_pkg::pool_result_t exp);
        bit seen;
        seen = 1'b0;
        for (int n = 0; n < run_limit && !seen; n++)
        begin
            @(negedge clk);
            seen = finish;
        end
        if (!seen)
        begin
            $display("finish did not arrive within %0d cycles", run_limit);
            misc_errors++;
        end
        check_level("busy", busy, 1'b0);
        check_result(exp);
    endtask

    task automatic run_and_check(input lenet_pkg::kernel_t k);
        lenet_pkg::pool_result_t exp;
        exp = model_result(k);
        load_image();
        start_run(k);
        finish_and_check(exp);
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    task automatic test_identity();
        lenet_pkg::kernel_t k;
        k = '0;
        k.weight[n_taps / 2] = 8'd16;
        for (int i = 0; i < n_pix; i++)
            image[i] = 8'(i * 37 + 11);
        run_and_check(k);
    endtask

    task automatic test_random();
        random_image();
        run_and_check(random_kernel());
    endtask

    task automatic test_negative();
        lenet_pkg::kernel_t k;
        for (int t = 0; t < n_taps; t++)
            k.weight[t] = 8'(-(t + 1));
        k.bias = 8'hfd;
        for (int i = 0; i < n_pix; i++)
            image[i] = 8'(lfsr_bits(8)) | 8'h01;
        run_and_check(k);
        check_zero();
    endtask

    task automatic test_back_to_back();
        lenet_pkg::kernel_t      k;
        lenet_pkg::pool_result_t exp;
        int                      count_before;
        random_image();
        run_and_check(random_kernel());
        random_image();
        k   = random_kernel();
        exp = model_result(k);
        load_image();
        count_before = finish_count;
        start_run(k);
        repeat (20) @(negedge clk);
        check_level("busy", busy, 1'b1);
        // second start lands mid-run
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        finish_and_check(exp);
        repeat (20) @(negedge clk);
        check_level("busy", busy, 1'b0);
        if (finish_count != count_before + 1)
        begin
            $display("expected one finish for the accepted start, counted %0d",
                     finish_count - count_before);
            misc_errors++;
        end
    endtask

    task automatic test_reset_mid_run();
        int count_at_reset;
        random_image();
        load_image();
        start_run(random_kernel());
        repeat (100) @(negedge clk);
        @(posedge clk);
        rst <= 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_level("busy", busy, 1'b0);
        check_zero();
        count_at_reset = finish_count;
        @(posedge clk);
        rst <= 1'b0;
        random_image();
        run_and_check(random_kernel());
        @(negedge clk);
        // the aborted run adds no finish of its own
        if (finish_count != count_at_reset + 1)
        begin
            $display("expected one finish after the reset, counted %0d",
                     finish_count - count_at_reset);
            misc_errors++;
        end
    endtask

    initial
    begin
        clk        = 1'b0;
        rst        = 1'b1;
        start      = 1'b0;
        img_wr     = '0;
        kernel     = '0;
        lfsr_state = 32'h4326;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        test_identity();
        test_random();
        test_negative();
        test_back_to_back();
        test_reset_mid_run();
        repeat (4) @(posedge clk);
        $display("value errors: %0d, other errors: %0d", val_errors, misc_errors);
        if (val_errors == 0 && misc_errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- lenet_top.sv
`default_nettype none

`include "lenet_settings.svh"

module lenet_top
(
    input  wire                     clk,
    input  wire                     rst,
    input  wire lenet_pkg::mem_wr_t img_wr,
    input  wire lenet_pkg::kernel_t kernel,
    input  wire                     start,
    output logic                    busy,
    output logic                    finish,
    output lenet_pkg::pool_result_t result
);

    lenet_pkg::mem_rd_t img_rd;
    lenet_pkg::mem_wr_t map_wr;
    lenet_pkg::mem_rd_t map_rd;
    logic [`DATA_W-1:0] img_data;
    logic [`DATA_W-1:0] map_data;
    logic               conv_start;
    logic               conv_done;
    logic               pool_start;
    logic               pool_done;

    layer_sequencer seq_i (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .conv_done  (conv_done),
        .pool_done  (pool_done),
        .conv_start (conv_start),
        .pool_start (pool_start),
        .busy       (busy),
        .finish     (finish)
    );

    // host fills the image while idle
    line_buffer_mem #(.depth(`IMG_DIM * `IMG_DIM)) image_mem (
        .clk     (clk),
        .wr      (img_wr),
        .rd      (img_rd),
        .rd_data (img_data)
    );

    conv_engine conv_i (
        .clk        (clk),
        .rst        (rst),
        .conv_start (conv_start),
        .kernel     (kernel),
        .img_rd     (img_rd),
        .img_data   (img_data),
        .map_wr     (map_wr),
        .conv_done  (conv_done)
    );

    // 6x6 feature map between the two stages
    line_buffer_mem #(.depth(`MAP_DIM * `MAP_DIM)) feature_mem (
        .clk     (clk),
        .wr      (map_wr),
        .rd      (map_rd),
        .rd_data (map_data)
    );

    pool_engine pool_i (
        .clk        (clk),
        .rst        (rst),
        .pool_start (pool_start),
        .map_rd     (map_rd),
        .map_data   (map_data),
        .result     (result),
        .pool_done  (pool_done)
    );

endmodule

`default_nettype wire

//--- line_buffer_mem.sv
`default_nettype none

`include "lenet_settings.svh"

// single writer, single reader, registered read
module line_buffer_mem
#(
    parameter int depth = 64
)
(
    input  wire                     clk,
    input  wire lenet_pkg::mem_wr_t wr,
    input  wire lenet_pkg::mem_rd_t rd,
    output logic [`DATA_W-1:0]      rd_data
);

    logic [`DATA_W-1:0] mem [depth];

    ////////////////////////////////////////////////////////////
    // write port
    always_ff @(posedge clk)
    begin
        if (wr.en)
        begin
            mem[wr.addr] <= wr.data;
        end
    end

    ////////////////////////////////////////////////////////////
    // read port, one cycle latency
    always_ff @(posedge clk)
    begin
        if (rd.en)
        begin
            rd_data <= mem[rd.addr];
        end
    end

endmodule

`default_nettype wire

//--- pool_engine.sv
`default_nettype none

`include "lenet_settings.svh"

module pool_engine
(
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      pool_start,
    output lenet_pkg::mem_rd_t       map_rd,
    input  wire [`DATA_W-1:0]        map_data,
    output lenet_pkg::pool_result_t  result,
    output logic                     pool_done
);

    localparam int blk_w  = $clog2(`POOL_DIM);
    localparam int slot_w = $clog2(`POOL_DIM * `POOL_DIM);

    logic              running;
    logic [blk_w-1:0]  br;
    logic [blk_w-1:0]  bc;
    logic [1:0]        quad;
    logic              rd_vld;
    logic [1:0]        quad_q;
    logic [slot_w-1:0] slot_q;

    logic signed [`DATA_W-1:0] cur;
    logic signed [`DATA_W-1:0] mx;
    logic signed [`DATA_W-1:0] mx_next;

    ////////////////////////////////////////////////////////////
    // four reads per block, quad bit 1 picks the row
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            running <= 1'b0;
            br      <= '0;
            bc      <= '0;
            quad    <= '0;
        end
        else if (!running)
        begin
            running <= pool_start;
        end
        else
        begin
            quad <= quad + 1'b1;
            if (quad == 2'd3)
            begin
                bc <= bc + 1'b1;
                if (bc == blk_w'(`POOL_DIM - 1))
                begin
                    bc <= '0;
                    br <= br + 1'b1;
                    if (br == blk_w'(`POOL_DIM - 1))
                    begin
                        br      <= '0;
                        running <= 1'b0;
                    end
                end
            end
        end
    end

    always_comb
    begin
        map_rd.en   = running;
        map_rd.addr = `ADDR_W'((br * 2 + quad[1]) * `MAP_DIM + bc * 2 + quad[0]);
        cur         = $signed(map_data);
        // first word of a block restarts the maximum
        mx_next     = (quad_q == 2'd0 || cur > mx) ? cur : mx;
    end

    ////////////////////////////////////////////////////////////
    // block result with relu
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rd_vld    <= 1'b0;
            pool_done <= 1'b0;
            result    <= '0;
        end
        else
        begin
            rd_vld    <= running;
            pool_done <= 1'b0;
            if (rd_vld && quad_q == 2'd3)
            begin
                result.value[slot_q] <= mx_next[`DATA_W-1] ? '0 : mx_next;
                pool_done <= (slot_q == slot_w'(`POOL_DIM * `POOL_DIM - 1));
            end
        end
    end

    always_ff @(posedge clk)
    begin
        quad_q <= quad;
        slot_q <= slot_w'(br * `POOL_DIM + bc);
        if (rd_vld)
            mx <= mx_next;
    end

endmodule

`default_nettype wire
